// File: verilog/axi_xbar_params.svh
`ifndef AXI_XBAR_PARAMS_SVH
`define AXI_XBAR_PARAMS_SVH

// ******************************
// Bus widths
// ******************************
`define ADDR_WIDTH  16
`define DATA_WIDTH  32
`define STRB_WIDTH  (`DATA_WIDTH / 8)

// ******************************
// Slave population
// ******************************
`define NUM_RAM     4
`define NUM_SLV     (`NUM_RAM + 1)  // RAMs plus the control block.
`define RAM_DEPTH   64              // Words per RAM.

// Region codes come from the top nibble of the address.
`define CTRL_REGION 4'h4

// Control register selects.
`define CTRL_SEL_MASK    2'd0
`define CTRL_SEL_SCRATCH 2'd1

`endif

// File: verilog/axi_xbar_pkg.sv
`include "axi_xbar_params.svh"

package axi_xbar_pkg;

    // Address as seen by a RAM slave.
    typedef struct packed {
        logic [3:0] region;
        logic [3:0] unused;
        logic [5:0] word;
        logic [1:0] bytesel;
    } ram_addr_t;

    // Address as seen by the control block.
    typedef struct packed {
        logic [3:0] region;
        logic [7:0] unused;
        logic [1:0] sel;      // Register select.
        logic [1:0] bytesel;
    } ctrl_addr_t;

    typedef union packed {
        ram_addr_t  ram;
        ctrl_addr_t ctrl;
    } axi_addr_u;

    typedef struct packed {
        axi_addr_u addr;
    } aw_chan_t;            // Also carries AR.

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic [`STRB_WIDTH-1:0] strb;
    } w_chan_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        resp_e resp;
    } b_chan_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        resp_e                  resp;
    } r_chan_t;

    typedef enum logic [2:0] {
        TGT_RAM0,
        TGT_RAM1,
        TGT_RAM2,
        TGT_RAM3,
        TGT_CTRL,
        TGT_ERR
    } tgt_e;

endpackage

// File: verilog/axi_slave_mux_a.sv
`timescale 1ns/10ps
`include "axi_xbar_params.svh"

module axi_slave_mux_a import axi_xbar_pkg::*; (
    input  logic                avalid,
    output logic                aready,
    input  axi_addr_u           addr,
    input  logic                hold,
    output logic [`NUM_SLV-1:0] tgt_valid,
    input  logic [`NUM_SLV-1:0] tgt_ready,
    output tgt_e                tgt
);

    // ******************************
    // Region decode
    // ******************************
    always_comb begin
        case (addr.ram.region)
            4'h0: begin
                tgt = TGT_RAM0;
            end
            4'h1: begin
                tgt = TGT_RAM1;
            end
            4'h2: begin
                tgt = TGT_RAM2;
            end
            4'h3: begin
                tgt = TGT_RAM3;
            end
            `CTRL_REGION: begin
                tgt = TGT_CTRL;
            end
            default: begin
                tgt = TGT_ERR;    // Unmapped regions go to the router.
            end
        endcase
    end

    // ******************************
    // Valid fan-out, ready select
    // ******************************
    always_comb begin
        tgt_valid = '0;
        aready    = 1'b0;
        if (!hold) begin
            if (tgt == TGT_ERR) begin
                // Error target takes the address at once.
                aready = avalid;
            end else begin
                tgt_valid[tgt] = avalid;
                aready         = avalid & tgt_ready[tgt];
            end
        end
    end

endmodule

// File: verilog/axi_resp_router.sv
`timescale 1ns/10ps
`include "axi_xbar_params.svh"

module axi_resp_router import axi_xbar_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst,
    // Write address and data.
    input  logic                          awvalid,
    input  logic                          awready_mux,
    input  tgt_e                          aw_tgt,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [`NUM_SLV-1:0]           w_tgt_valid,
    // Write response.
    output logic                          bvalid,
    input  logic                          bready,
    output b_chan_t                       b,
    input  logic [`NUM_SLV-1:0]           s_bvalid,
    input  b_chan_t [`NUM_SLV-1:0]        s_b,
    output logic [`NUM_SLV-1:0]           s_bready,
    // Read address and data.
    input  tgt_e                          ar_tgt,
    input  logic                          arvalid,
    input  logic                          arready_mux,
    output logic                          rvalid,
    input  logic                          rready,
    output r_chan_t                       r,
    input  logic [`NUM_SLV-1:0]           s_rvalid,
    input  r_chan_t [`NUM_SLV-1:0]        s_r,
    output logic [`NUM_SLV-1:0]           s_rready,
    // Address stalls back to the muxes.
    output logic                          aw_hold,
    output logic                          ar_hold
);

    tgt_e b_tgt;
    tgt_e r_tgt;
    logic aw_hs;
    logic ar_hs;

    assign aw_hs  = awvalid & awready_mux;
    assign ar_hs  = arvalid & arready_mux;
    assign wready = aw_hs;    // W rides along with AW.

    always_comb begin
        w_tgt_valid = '0;
        if (!aw_hold && aw_tgt != TGT_ERR) begin
            w_tgt_valid[aw_tgt] = wvalid;
        end
    end

    // ******************************
    // Outstanding transaction state
    // ******************************
    always_ff @(posedge clk_i) begin
        if (rst) begin
            aw_hold <= 1'b0;
            b_tgt   <= TGT_ERR;
        end else if (aw_hs) begin
            aw_hold <= 1'b1;
            b_tgt   <= aw_tgt;
        end else if (bvalid && bready) begin
            aw_hold <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            ar_hold <= 1'b0;
            r_tgt   <= TGT_ERR;
        end else if (ar_hs) begin
            ar_hold <= 1'b1;
            r_tgt   <= ar_tgt;
        end else if (rvalid && rready) begin
            ar_hold <= 1'b0;
        end
    end

    // ******************************
    // Response return
    // ******************************
    always_comb begin
        bvalid   = 1'b0;
        b.resp   = OKAY;
        s_bready = '0;
        if (aw_hold) begin
            if (b_tgt == TGT_ERR) begin
                bvalid = 1'b1;    // Decode error answered here.
                b.resp = DECERR;
            end else begin
                bvalid          = s_bvalid[b_tgt];
                b               = s_b[b_tgt];
                s_bready[b_tgt] = bready;
            end
        end
    end

    always_comb begin
        rvalid   = 1'b0;
        r        = '{data: '0, resp: OKAY};
        s_rready = '0;
        if (ar_hold) begin
            if (r_tgt == TGT_ERR) begin
                rvalid = 1'b1;
                r.resp = DECERR;  // Data stays zero.
            end else begin
                rvalid          = s_rvalid[r_tgt];
                r               = s_r[r_tgt];
                s_rready[r_tgt] = rready;
            end
        end
    end

endmodule

// File: verilog/axi_lite_ram.sv
`timescale 1ns/10ps
`include "axi_xbar_params.svh"

module axi_lite_ram import axi_xbar_pkg::*; (
    input  logic     clk_i,
    input  logic     rst,
    input  logic     awvalid,
    output logic     awready,
    input  aw_chan_t aw,
    input  logic     wvalid,
    output logic     wready,
    input  w_chan_t  w,
    input  logic     write_en,
    output logic     bvalid,
    input  logic     bready,
    output b_chan_t  b,
    input  logic     arvalid,
    output logic     arready,
    input  aw_chan_t ar,
    output logic     rvalid,
    input  logic     rready,
    output r_chan_t  r
);

    logic [`DATA_WIDTH-1:0] mem [`RAM_DEPTH];
    logic                   wr_hs;
    logic                   rd_hs;

    // AW and W are taken together, one B at a time.
    assign awready = wvalid & ~bvalid;
    assign wready  = awvalid & ~bvalid;
    assign arready = ~rvalid;
    assign wr_hs   = awvalid & wvalid & ~bvalid;
    assign rd_hs   = arvalid & ~rvalid;

    // ******************************
    // Response handshakes
    // ******************************
    always_ff @(posedge clk_i) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ******************************
    // Storage
    // ******************************
    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            b.resp <= write_en ? OKAY : SLVERR;   // Refused writes leave memory alone.
            if (write_en) begin
                for (int i = 0; i < `STRB_WIDTH; i++) begin
                    if (w.strb[i]) begin
                        mem[aw.addr.ram.word][8*i +: 8] <= w.data[8*i +: 8];
                    end
                end
            end
        end
        if (rd_hs) begin
            r.data <= mem[ar.addr.ram.word];
            r.resp <= OKAY;
        end
    end

endmodule

// File: verilog/axi_ctrl_regs.sv
`timescale 1ns/10ps
`include "axi_xbar_params.svh"

module axi_ctrl_regs import axi_xbar_pkg::*; (
    input  logic                clk_i,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  aw_chan_t            aw,
    input  logic                wvalid,
    output logic                wready,
    input  w_chan_t             w,
    output logic                bvalid,
    input  logic                bready,
    output b_chan_t             b,
    input  logic                arvalid,
    output logic                arready,
    input  aw_chan_t            ar,
    output logic                rvalid,
    input  logic                rready,
    output r_chan_t             r,
    output logic [`NUM_RAM-1:0] we_mask
);

    logic [`DATA_WIDTH-1:0] scratch;
    logic                   wr_hs;
    logic                   rd_hs;

    assign awready = wvalid & ~bvalid;
    assign wready  = awvalid & ~bvalid;
    assign arready = ~rvalid;
    assign wr_hs   = awvalid & wvalid & ~bvalid;
    assign rd_hs   = arvalid & ~rvalid;
    assign b.resp  = OKAY;       // Every access here succeeds.

    always_ff @(posedge clk_i) begin
        if (rst) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            we_mask <= '1;       // All RAMs writable out of reset.
            scratch <= '0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
                if (aw.addr.ctrl.sel == `CTRL_SEL_MASK && w.strb[0]) begin
                    we_mask <= w.data[`NUM_RAM-1:0];
                end
                if (aw.addr.ctrl.sel == `CTRL_SEL_SCRATCH) begin
                    for (int i = 0; i < `STRB_WIDTH; i++) begin
                        if (w.strb[i]) begin
                            scratch[8*i +: 8] <= w.data[8*i +: 8];
                        end
                    end
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read data register. Selects 2 and 3 read as zero.
    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            r.resp <= OKAY;
            case (ar.addr.ctrl.sel)
                `CTRL_SEL_MASK:    r.data <= {{(`DATA_WIDTH-`NUM_RAM){1'b0}}, we_mask};
                `CTRL_SEL_SCRATCH: r.data <= scratch;
                default:           r.data <= '0;
            endcase
        end
    end

endmodule

// File: verilog/axi_xbar_top.sv
`timescale 1ns/10ps
`include "axi_xbar_params.svh"

module axi_xbar_top import axi_xbar_pkg::*; (
    input  logic     clk_i,
    input  logic     rst,
    input  logic     awvalid,
    output logic     awready,
    input  aw_chan_t aw,
    input  logic     wvalid,
    output logic     wready,
    input  w_chan_t  w,
    output logic     bvalid,
    input  logic     bready,
    output b_chan_t  b,
    input  logic     arvalid,
    output logic     arready,
    input  aw_chan_t ar,
    output logic     rvalid,
    input  logic     rready,
    output r_chan_t  r
);

    logic [`NUM_SLV-1:0]    aw_tgt_valid;
    logic [`NUM_SLV-1:0]    s_awready;
    logic [`NUM_SLV-1:0]    w_tgt_valid;
    logic [`NUM_SLV-1:0]    ar_tgt_valid;
    logic [`NUM_SLV-1:0]    s_arready;
    logic [`NUM_SLV-1:0]    s_bvalid;
    logic [`NUM_SLV-1:0]    s_bready;
    logic [`NUM_SLV-1:0]    s_rvalid;
    logic [`NUM_SLV-1:0]    s_rready;
    b_chan_t [`NUM_SLV-1:0] s_b;
    r_chan_t [`NUM_SLV-1:0] s_r;
    logic [`NUM_RAM-1:0]    we_mask;
    tgt_e                   aw_tgt;
    tgt_e                   ar_tgt;
    logic                   aw_hold;
    logic                   ar_hold;

    // ******************************
    // Address decode
    // ******************************
    axi_slave_mux_a u_aw_mux (
        .avalid    (awvalid),
        .aready    (awready),
        .addr      (aw.addr),
        .hold      (aw_hold),
        .tgt_valid (aw_tgt_valid),
        .tgt_ready (s_awready),
        .tgt       (aw_tgt)
    );

    axi_slave_mux_a u_ar_mux (
        .avalid    (arvalid),
        .aready    (arready),
        .addr      (ar.addr),
        .hold      (ar_hold),
        .tgt_valid (ar_tgt_valid),
        .tgt_ready (s_arready),
        .tgt       (ar_tgt)
    );

    axi_resp_router u_router (
        .clk_i       (clk_i),
        .rst         (rst),
        .awvalid     (awvalid),
        .awready_mux (awready),
        .aw_tgt      (aw_tgt),
        .wvalid      (wvalid),
        .wready      (wready),
        .w_tgt_valid (w_tgt_valid),
        .bvalid      (bvalid),
        .bready      (bready),
        .b           (b),
        .s_bvalid    (s_bvalid),
        .s_b         (s_b),
        .s_bready    (s_bready),
        .ar_tgt      (ar_tgt),
        .arvalid     (arvalid),
        .arready_mux (arready),
        .rvalid      (rvalid),
        .rready      (rready),
        .r           (r),
        .s_rvalid    (s_rvalid),
        .s_r         (s_r),
        .s_rready    (s_rready),
        .aw_hold     (aw_hold),
        .ar_hold     (ar_hold)
    );

    // ******************************
    // Slaves
    // ******************************
    for (genvar g = 0; g < `NUM_RAM; g++) begin : g_ram
        axi_lite_ram u_ram (
            .clk_i    (clk_i),
            .rst      (rst),
            .awvalid  (aw_tgt_valid[g]),
            .awready  (s_awready[g]),
            .aw       (aw),
            .wvalid   (w_tgt_valid[g]),
            .wready   (),               // W is taken with AW.
            .w        (w),
            .write_en (we_mask[g]),
            .bvalid   (s_bvalid[g]),
            .bready   (s_bready[g]),
            .b        (s_b[g]),
            .arvalid  (ar_tgt_valid[g]),
            .arready  (s_arready[g]),
            .ar       (ar),
            .rvalid   (s_rvalid[g]),
            .rready   (s_rready[g]),
            .r        (s_r[g])
        );
    end

    axi_ctrl_regs u_ctrl (
        .clk_i   (clk_i),
        .rst     (rst),
        .awvalid (aw_tgt_valid[`NUM_RAM]),
        .awready (s_awready[`NUM_RAM]),
        .aw      (aw),
        .wvalid  (w_tgt_valid[`NUM_RAM]),
        .wready  (),
        .w       (w),
        .bvalid  (s_bvalid[`NUM_RAM]),
        .bready  (s_bready[`NUM_RAM]),
        .b       (s_b[`NUM_RAM]),
        .arvalid (ar_tgt_valid[`NUM_RAM]),
        .arready (s_arready[`NUM_RAM]),
        .ar      (ar),
        .rvalid  (s_rvalid[`NUM_RAM]),
        .rready  (s_rready[`NUM_RAM]),
        .r       (s_r[`NUM_RAM]),
        .we_mask (we_mask)
    );

endmodule

// File: bench/axi_xbar_clk_gen.sv
`timescale 1ns/10ps

module axi_xbar_clk_gen #(
    parameter real period = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2.0) clk = ~clk;    // Half period per phase.
        end
    end

endmodule

// File: bench/axi_xbar_asserts.sv
`timescale 1ns/10ps
`include "axi_xbar_params.svh"

module axi_xbar_asserts import axi_xbar_pkg::*; (
    input logic                clk_i,
    input logic                rst,
    input logic                awready,
    input logic                wready,
    input logic                arready,
    input logic                bvalid,
    input logic                bready,
    input b_chan_t             b,
    input logic                rvalid,
    input logic                rready,
    input r_chan_t             r,
    input logic [`NUM_SLV-1:0] aw_tgt_valid,
    input logic [`NUM_SLV-1:0] ar_tgt_valid
);

    int fail_count = 0;

    property hold_until_ready(valid, ready);
        @(posedge clk_i) disable iff (rst) valid && !ready |=> valid;
    endproperty

    // ******************************
    // Response channels
    // ******************************
    a_b_hold: assert property (hold_until_ready(bvalid, bready))
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end
    a_b_stable: assert property (@(posedge clk_i) disable iff (rst)
        bvalid && !bready |=> $stable(b))
        else begin
            $error("B payload changed while waiting for bready");
            fail_count++;
        end
    a_r_hold: assert property (hold_until_ready(rvalid, rready))
        else begin
            $error("rvalid dropped before rready");
            fail_count++;
        end
    a_r_stable: assert property (@(posedge clk_i) disable iff (rst)
        rvalid && !rready |=> $stable(r))
        else begin
            $error("R payload changed while waiting for rready");
            fail_count++;
        end

    // Only one slave sees an address at a time.
    a_aw_onehot: assert property (@(posedge clk_i) disable iff (rst) $onehot0(aw_tgt_valid))
        else begin
            $error("write mux drives more than one target valid");
            fail_count++;
        end
    a_ar_onehot: assert property (@(posedge clk_i) disable iff (rst) $onehot0(ar_tgt_valid))
        else begin
            $error("read mux drives more than one target valid");
            fail_count++;
        end

    a_reset: assert property (@(posedge clk_i)
        $fell(rst) |-> !awready && !wready && !arready && !bvalid && !rvalid)
        else begin
            $error("master-side handshake signals high right after reset");
            fail_count++;
        end

endmodule

bind axi_xbar_top axi_xbar_asserts u_asserts (
    .clk_i        (clk_i),
    .rst          (rst),
    .awready      (awready),
    .wready       (wready),
    .arready      (arready),
    .bvalid       (bvalid),
    .bready       (bready),
    .b            (b),
    .rvalid       (rvalid),
    .rready       (rready),
    .r            (r),
    .aw_tgt_valid (aw_tgt_valid),
    .ar_tgt_valid (ar_tgt_valid)
);

// File: bench/axi_xbar_tb.sv
`timescale 1ns/10ps
`include "axi_xbar_params.svh"

module axi_xbar_tb import axi_xbar_pkg::*;;

    localparam int num_ops        = 400;
    localparam int fill_ops       = `NUM_RAM * `RAM_DEPTH;
    localparam int timeout_cycles = (num_ops + fill_ops + 16) * 20;

    logic     clk_i;
    logic     rst;
    logic     awvalid;
    logic     awready;
    aw_chan_t aw;
    logic     wvalid;
    logic     wready;
    w_chan_t  w;
    logic     bvalid;
    logic     bready;
    b_chan_t  b;
    logic     arvalid;
    logic     arready;
    aw_chan_t ar;
    logic     rvalid;
    logic     rready;
    r_chan_t  r;

    // Reference model state.
    logic [`DATA_WIDTH-1:0] ram_m [`NUM_RAM][`RAM_DEPTH];
    logic [`NUM_RAM-1:0]    mask_m;
    logic [`DATA_WIDTH-1:0] scratch_m;
    int                     errors;
    int                     checks;

    axi_xbar_clk_gen #(.period(8.0)) u_clk (.clk(clk_i));

    axi_xbar_top dut0 (
        .clk_i   (clk_i),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .b       (b),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

    function automatic logic [15:0] make_addr(input logic [3:0] region, input logic [5:0] word);
        return {region, 4'h0, word, 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [15:0] addr,
                           input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s at addr %h: expected %h, got %h", name, addr, exp, got);
        end
    endtask

    // ******************************
    // Bus transactions
    // ******************************
    task automatic do_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output resp_e resp);
        @(posedge clk_i);
        awvalid <= 1'b1;
        aw.addr <= addr;
        wvalid  <= 1'b1;
        w.data  <= data;
        w.strb  <= strb;
        @(negedge clk_i);
        compare("bvalid", addr, 32'(bvalid), 32'd0);  // Nothing left over.
        while (!awready) begin
            @(negedge clk_i);
        end
        compare("wready", addr, 32'(wready), 32'd1);
        @(posedge clk_i);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= ($urandom % 3) != 0;
        @(negedge clk_i);
        compare("bvalid", addr, 32'(bvalid), 32'd1);   // One cycle after the handshake.
        while (!bready) begin
            @(posedge clk_i);
            bready <= ($urandom % 3) != 0;
            @(negedge clk_i);
            compare("bvalid", addr, 32'(bvalid), 32'd1);
        end
        resp = b.resp;
        @(posedge clk_i);
        bready <= 1'b0;
    endtask

    task automatic do_read(input logic [15:0] addr, output logic [31:0] data, output resp_e resp);
        @(posedge clk_i);
        arvalid <= 1'b1;
        ar.addr <= addr;
        @(negedge clk_i);
        compare("rvalid", addr, 32'(rvalid), 32'd0);
        while (!arready) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        arvalid <= 1'b0;
        rready  <= ($urandom % 3) != 0;
        @(negedge clk_i);
        compare("rvalid", addr, 32'(rvalid), 32'd1);
        while (!rready) begin
            @(posedge clk_i);
            rready <= ($urandom % 3) != 0;
            @(negedge clk_i);
            compare("rvalid", addr, 32'(rvalid), 32'd1);
        end
        data = r.data;
        resp = r.resp;
        @(posedge clk_i);
        rready <= 1'b0;
    endtask

    // ******************************
    // Model and checks
    // ******************************
    task automatic check_write(input logic [15:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [3:0] region;
        logic [5:0] word;
        resp_e      exp;
        resp_e      got;
        region = addr[15:12];
        word   = addr[7:2];
        if (region < `NUM_RAM) begin
            exp = mask_m[region[1:0]] ? OKAY : SLVERR;
            if (mask_m[region[1:0]]) begin
                ram_m[region[1:0]][word] = merge_bytes(ram_m[region[1:0]][word], data, strb);
            end
        end else if (region == `CTRL_REGION) begin
            exp = OKAY;
            if (addr[3:2] == 2'd0 && strb[0]) begin
                mask_m = data[`NUM_RAM-1:0];
            end
            if (addr[3:2] == 2'd1) begin
                scratch_m = merge_bytes(scratch_m, data, strb);
            end
        end else begin
            exp = DECERR;
        end
        do_write(addr, data, strb, got);
        compare("b.resp", addr, 32'(got), 32'(exp));
    endtask

    task automatic check_read(input logic [15:0] addr);
        logic [3:0]  region;
        logic [31:0] exp_data;
        logic [31:0] got_data;
        resp_e       exp;
        resp_e       got;
        region   = addr[15:12];
        exp      = OKAY;
        exp_data = '0;
        if (region < `NUM_RAM) begin
            exp_data = ram_m[region[1:0]][addr[7:2]];
        end else if (region == `CTRL_REGION) begin
            case (addr[3:2])
                2'd0:    exp_data = 32'(mask_m);
                2'd1:    exp_data = scratch_m;
                default: exp_data = '0;
            endcase
        end else begin
            exp = DECERR;    // Data stays zero.
        end
        do_read(addr, got_data, got);
        compare("r.resp", addr, 32'(got), 32'(exp));
        compare("r.data", addr, got_data, exp_data);
    endtask

    initial begin
        logic [15:0] addr;
        void'($urandom(32));
        errors    = 0;
        checks    = 0;
        mask_m    = '1;
        scratch_m = '0;
        rst     <= 1'b1;
        awvalid <= 1'b0;
        aw      <= '0;
        wvalid  <= 1'b0;
        w       <= '0;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        ar      <= '0;
        rready  <= 1'b0;
        repeat (8) @(posedge clk_i);
        rst <= 1'b0;
        check_read(16'h4000);    // Mask after reset.
        check_read(16'h4004);
        // Known contents in every RAM word.
        for (int k = 0; k < `NUM_RAM; k++) begin
            for (int j = 0; j < `RAM_DEPTH; j++) begin
                addr = make_addr(4'(k), 6'(j));
                check_write(addr, {~addr, addr}, 4'hF);
            end
        end
        // Lock RAM1 and RAM3 and try a refused write.
        check_write(16'h4000, 32'h0000_0005, 4'h1);
        check_write(make_addr(4'd1, 6'd5), 32'hDEAD_BEEF, 4'hF);
        check_read(make_addr(4'd1, 6'd5));
        check_write(16'h4000, 32'h0000_000F, 4'h1);
        repeat (num_ops) begin
            addr = make_addr(4'($urandom % 8), 6'($urandom % 64));
            if ($urandom % 2) begin
                check_write(addr, $urandom, 4'($urandom % 16));
            end else begin
                check_read(addr);
            end
        end
        repeat (2) @(posedge clk_i);
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_asserts.fail_count);
        if (errors == 0 && dut0.u_asserts.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        repeat (timeout_cycles) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

// File: axi_xbar.f
+incdir+verilog
verilog/axi_xbar_pkg.sv
verilog/axi_slave_mux_a.sv
verilog/axi_resp_router.sv
verilog/axi_lite_ram.sv
verilog/axi_ctrl_regs.sv
verilog/axi_xbar_top.sv
bench/axi_xbar_clk_gen.sv
bench/axi_xbar_asserts.sv
bench/axi_xbar_tb.sv

// File: Bender.yml
package:
  name: axi_xbar

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/axi_xbar_pkg.sv
      - verilog/axi_slave_mux_a.sv
      - verilog/axi_resp_router.sv
      - verilog/axi_lite_ram.sv
      - verilog/axi_ctrl_regs.sv
      - verilog/axi_xbar_top.sv
  - target: test
    files:
      - bench/axi_xbar_clk_gen.sv
      - bench/axi_xbar_asserts.sv
      - bench/axi_xbar_tb.sv
